// ==== rtl/bp_pkg.sv ====
package bp_pkg;

    localparam int PC_W   = 18; // half-word pc, bits 18:1
    localparam int HIST_W = 7;
    localparam int CTR_W  = 2;
    localparam int IDX_W  = 5;

    typedef logic [PC_W:1]     pc_t;
    typedef logic [HIST_W-1:0] hist_t;
    typedef logic [CTR_W-1:0]  ctr_t;
    typedef logic [IDX_W-1:0]  tbl_idx_t; // default table index, 32 entries

    // correction code sent back to the core
    typedef logic [1:0] fix_t;

    localparam fix_t FIX_NONE      = 2'd0;
    localparam fix_t FIX_NOT_TAKEN = 2'd1; // said taken, fell through
    localparam fix_t FIX_TAKEN     = 2'd2; // said not taken, branch went elsewhere
    localparam fix_t FIX_TARGET    = 2'd3; // taken, but to another target

    localparam ctr_t CTR_MIN = '0;
    localparam ctr_t CTR_MAX = '1;

    // one decode or execute stage entry
    typedef struct packed {
        logic live;
        pc_t  pc;
        logic pred_taken;
        logic compressed;
    } stage_t;

    // a branch leaving execute, seen by all three tables
    typedef struct packed {
        logic valid;
        pc_t  pc;
        logic taken;
        pc_t  target;
        logic miss;
        logic jump;
        logic pred_taken;
    } resolve_t;

endpackage

// ==== rtl/branch_target_buffer.sv ====
module branch_target_buffer #(
    parameter int TABLE_DEPTH = 32
) (
    input  logic             clk_i,
    input  logic             rst_i,
    input  bp_pkg::pc_t      pc_i,
    input  bp_pkg::resolve_t resolve_i,
    output bp_pkg::pc_t      pred_target_o
);

    localparam int IDX_W = $clog2(TABLE_DEPTH);

    // untagged, direct mapped on the low pc bits
    bp_pkg::pc_t targets [TABLE_DEPTH];

    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    logic             wr_en;

    assign rd_idx = pc_i[IDX_W:1];
    assign wr_idx = resolve_i.pc[IDX_W:1];

    // only a taken miss brings a new target; a not taken miss keeps the old one
    assign wr_en = resolve_i.valid && resolve_i.miss && resolve_i.taken;

    assign pred_target_o = targets[rd_idx]; // same cycle as the fetch pc

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < TABLE_DEPTH; i++) begin
                targets[i] <= '0;
            end
        end else if (wr_en) begin
            targets[wr_idx] <= resolve_i.target;
        end
    end

endmodule

// ==== rtl/pattern_history_table.sv ====
module pattern_history_table #(
    parameter int TABLE_DEPTH = 32
) (
    input  logic             clk_i,
    input  logic             rst_i,
    input  bp_pkg::pc_t      pc_i,
    input  bp_pkg::hist_t    read_hist_i,
    input  bp_pkg::hist_t    update_hist_i,
    input  bp_pkg::resolve_t resolve_i,
    output logic             pred_taken_o
);

    localparam int IDX_W = $clog2(TABLE_DEPTH);

    bp_pkg::ctr_t counters [TABLE_DEPTH];

    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;
    logic             upd_en;
    bp_pkg::ctr_t     cur_ctr;
    bp_pkg::ctr_t     next_ctr;

    // gshare, pc xor history
    assign rd_idx = pc_i[IDX_W:1] ^ read_hist_i[IDX_W-1:0];
    assign wr_idx = resolve_i.pc[IDX_W:1] ^ update_hist_i[IDX_W-1:0];

    assign pred_taken_o = counters[rd_idx][bp_pkg::CTR_W-1]; // upper bit

    // jumps are always taken, they would only skew the counters
    assign upd_en = resolve_i.valid && !resolve_i.jump;

    always_comb begin
        cur_ctr  = counters[wr_idx];
        next_ctr = cur_ctr;
        if (resolve_i.taken) begin
            if (cur_ctr != bp_pkg::CTR_MAX) begin
                next_ctr = cur_ctr + bp_pkg::ctr_t'(1);
            end
        end else if (cur_ctr != bp_pkg::CTR_MIN) begin
            next_ctr = cur_ctr - bp_pkg::ctr_t'(1);
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            for (int i = 0; i < TABLE_DEPTH; i++) begin
                counters[i] <= bp_pkg::CTR_MIN; // strongly not taken
            end
        end else if (upd_en) begin
            counters[wr_idx] <= next_ctr;
        end
    end

endmodule

// ==== rtl/global_history.sv ====
module global_history #(
    parameter int HIST_LEN = 7
) (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             predict_i,
    input  logic             pred_taken_i,
    input  bp_pkg::resolve_t resolve_i,
    output bp_pkg::hist_t    read_hist_o,
    output bp_pkg::hist_t    update_hist_o
);

    // speculative history, newest direction in bit 0
    logic [HIST_LEN-1:0] spec_hist;
    logic [HIST_LEN-1:0] retire_hist;

    // predicted but not yet resolved, at most decode plus execute
    logic [1:0] inflight;
    logic [1:0] inflight_next;
    logic       repair;

    // back off the younger predictions to see what the retiring branch saw
    assign retire_hist = spec_hist >> inflight;

    assign read_hist_o   = bp_pkg::hist_t'(spec_hist);
    assign update_hist_o = bp_pkg::hist_t'(retire_hist);

    assign repair = resolve_i.valid && resolve_i.miss;

    always_comb begin
        inflight_next = inflight;
        case ({predict_i, resolve_i.valid})
            2'b10: inflight_next = inflight + 2'd1;
            2'b01: inflight_next = inflight - 2'd1;
            default: inflight_next = inflight; // both or neither, net zero
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            spec_hist <= '0;
            inflight  <= '0;
        end else if (repair) begin
            // younger entries are flushed at this edge, nothing left in flight
            spec_hist <= {retire_hist[HIST_LEN-2:0], resolve_i.taken};
            inflight  <= '0;
        end else begin
            if (predict_i) begin
                spec_hist <= {spec_hist[HIST_LEN-2:0], pred_taken_i};
            end
            inflight <= inflight_next;
        end
    end

endmodule

// ==== rtl/resolve_tracker.sv ====
module resolve_tracker (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             stall_i,
    input  bp_pkg::pc_t      pc_i,
    input  logic             predict_i,
    input  logic             compressed_i,
    input  logic             pred_taken_i,
    input  logic             jump_i,
    input  logic             taken_i,
    input  bp_pkg::pc_t      target_i,
    output bp_pkg::fix_t     fix_o,
    output bp_pkg::resolve_t resolve_o,
    output bp_pkg::pc_t      exe_pc_o,
    output logic             exe_compressed_o
);

    bp_pkg::stage_t dec_q;
    bp_pkg::stage_t exe_q;
    bp_pkg::stage_t dec_d;
    bp_pkg::stage_t exe_d;

    logic next_match;
    logic miss;

    // decode holds whatever fetch brought in after the branch
    assign next_match = (dec_q.pc == target_i);

    always_comb begin
        fix_o = bp_pkg::FIX_NONE;
        if (exe_q.live && !(taken_i && next_match)) begin
            if (!taken_i) begin
                if (exe_q.pred_taken) begin
                    fix_o = bp_pkg::FIX_NOT_TAKEN;
                end
            end else if (exe_q.pred_taken) begin
                fix_o = bp_pkg::FIX_TARGET;
            end else begin
                fix_o = bp_pkg::FIX_TAKEN;
            end
        end
    end

    assign miss = (fix_o != bp_pkg::FIX_NONE);

    // next stage contents, live dropped on a miss
    always_comb begin
        dec_d.live       = predict_i && !miss;
        dec_d.pc         = pc_i;
        dec_d.pred_taken = pred_taken_i;
        dec_d.compressed = compressed_i;

        exe_d      = dec_q;
        exe_d.live = dec_q.live && !miss;
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            dec_q <= '0;
            exe_q <= '0;
        end else if (!stall_i) begin // hold both stages on stall
            dec_q <= dec_d;
            exe_q <= exe_d;
        end
    end

    always_comb begin
        resolve_o.valid      = exe_q.live && !stall_i; // train once, when it leaves
        resolve_o.pc         = exe_q.pc;
        resolve_o.taken      = taken_i;
        resolve_o.target     = target_i;
        resolve_o.miss       = miss;
        resolve_o.jump       = jump_i;
        resolve_o.pred_taken = exe_q.pred_taken;
    end

    assign exe_pc_o         = exe_q.pc;
    assign exe_compressed_o = exe_q.compressed;

endmodule

// ==== rtl/branch_predictor.sv ====
module branch_predictor #(
    parameter int TABLE_DEPTH = 1 << $bits(bp_pkg::tbl_idx_t),
    parameter int HIST_LEN    = $bits(bp_pkg::hist_t)
) (
    input  logic         clk_i,
    input  logic         rst_i,
    input  logic         stall_i,
    // fetch side
    input  bp_pkg::pc_t  pc_i,
    input  logic         predict_i,
    input  logic         compressed_i,
    output bp_pkg::pc_t  pred_target_o,
    output logic         pred_taken_o,
    // execute side
    input  logic         jump_i,
    input  logic         taken_i,
    input  bp_pkg::pc_t  target_i,
    output bp_pkg::fix_t fix_o,
    output bp_pkg::pc_t  exe_pc_o,
    output logic         exe_compressed_o
);

    bp_pkg::resolve_t resolve;
    bp_pkg::hist_t    read_hist;
    bp_pkg::hist_t    update_hist;
    logic             predict_accept;

    // a stalled fetch repeats its pc, count it once
    assign predict_accept = predict_i && !stall_i;

    branch_target_buffer #(.TABLE_DEPTH(TABLE_DEPTH)) btb_inst (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .pc_i          (pc_i),
        .resolve_i     (resolve),
        .pred_target_o (pred_target_o)
    );

    pattern_history_table #(.TABLE_DEPTH(TABLE_DEPTH)) pht_inst (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .pc_i          (pc_i),
        .read_hist_i   (read_hist),
        .update_hist_i (update_hist),
        .resolve_i     (resolve),
        .pred_taken_o  (pred_taken_o)
    );

    global_history #(.HIST_LEN(HIST_LEN)) ghist_inst (
        .clk_i         (clk_i),
        .rst_i         (rst_i),
        .predict_i     (predict_accept),
        .pred_taken_i  (pred_taken_o),
        .resolve_i     (resolve),
        .read_hist_o   (read_hist),
        .update_hist_o (update_hist)
    );

    resolve_tracker tracker_inst (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .stall_i          (stall_i),
        .pc_i             (pc_i),
        .predict_i        (predict_i),
        .compressed_i     (compressed_i),
        .pred_taken_i     (pred_taken_o),
        .jump_i           (jump_i),
        .taken_i          (taken_i),
        .target_i         (target_i),
        .fix_o            (fix_o),
        .resolve_o        (resolve),
        .exe_pc_o         (exe_pc_o),
        .exe_compressed_o (exe_compressed_o)
    );

endmodule

// ==== bench/branch_predictor_assertions.sv ====
module branch_predictor_assertions (
    input logic           clk_i,
    input logic           rst_i,
    input logic           stall_i,
    input bp_pkg::fix_t   fix_i,
    input bp_pkg::stage_t dec_i,
    input bp_pkg::stage_t exe_i
);

    // both stages empty and quiet right after reset
    reset_state: assert property (@(posedge clk_i)
        rst_i |=> (!dec_i.live && !exe_i.live && fix_i == bp_pkg::FIX_NONE))
        else $error("stages not empty after reset");

    // a miss kills both younger entries at the edge that ends it
    flush_on_miss: assert property (@(posedge clk_i) disable iff (rst_i)
        (fix_i != bp_pkg::FIX_NONE && !stall_i) |=> (!dec_i.live && !exe_i.live))
        else $error("younger entries survived a miss");

    // the flushed entry cannot raise a second correction
    single_fix: assert property (@(posedge clk_i) disable iff (rst_i)
        (fix_i != bp_pkg::FIX_NONE && !stall_i) |=> fix_i == bp_pkg::FIX_NONE)
        else $error("correction repeated after a flush");

    // a stall freezes both stages
    stall_hold: assert property (@(posedge clk_i) disable iff (rst_i)
        stall_i |=> (dec_i == $past(dec_i) && exe_i == $past(exe_i)))
        else $error("stage changed during a stall");

endmodule

// ==== bench/branch_predictor_tb.sv ====
module branch_predictor_tb;

    localparam int RAND_CYCLES = 400;
    localparam int TRAIN_MAX   = 12;
    localparam int CYCLE_LIMIT = 4 + TRAIN_MAX * 5 + 5 + TRAIN_MAX * 5 + 10 + 8 * 5 + 4
                                 + RAND_CYCLES + 64;

    typedef struct packed {
        logic         taken;
        bp_pkg::pc_t  target;
        bp_pkg::fix_t fix;
    } expect_t;

    logic         clk_i;
    logic         rst_i;
    logic         stall;
    bp_pkg::pc_t  pc;
    logic         predict;
    logic         compressed;
    logic         jump;
    logic         taken;
    bp_pkg::pc_t  target;
    bp_pkg::pc_t  pred_target_o;
    logic         pred_taken_o;
    bp_pkg::fix_t fix_o;
    bp_pkg::pc_t  exe_pc_o;
    logic         exe_compressed_o;

    // reference state
    bp_pkg::pc_t    m_btb [32];
    bp_pkg::ctr_t   m_ctr [32];
    bp_pkg::hist_t  m_hist;
    logic [1:0]     m_inflight;
    bp_pkg::stage_t m_dec;
    bp_pkg::stage_t m_exe;

    logic [31:0] lfsr_state = 32'hece1_9a04;
    int          errors = 0;
    int          checks = 0;
    int          cycle_count = 0;
    int          test_errors;
    string       test_name = "reset";

    branch_predictor #(.TABLE_DEPTH(32), .HIST_LEN(7)) branch_predictor_inst (
        .clk_i            (clk_i),
        .rst_i            (rst_i),
        .stall_i          (stall),
        .pc_i             (pc),
        .predict_i        (predict),
        .compressed_i     (compressed),
        .pred_target_o    (pred_target_o),
        .pred_taken_o     (pred_taken_o),
        .jump_i           (jump),
        .taken_i          (taken),
        .target_i         (target),
        .fix_o            (fix_o),
        .exe_pc_o         (exe_pc_o),
        .exe_compressed_o (exe_compressed_o)
    );

    bind resolve_tracker branch_predictor_assertions assertions_inst (
        .clk_i   (clk_i),
        .rst_i   (rst_i),
        .stall_i (stall_i),
        .fix_i   (fix_o),
        .dec_i   (dec_q),
        .exe_i   (exe_q)
    );

    always #4 clk_i = ~clk_i;

    // fibonacci lfsr with taps 32 22 2 1 stepped once per bit
    function automatic int take_bits(int n);
        int   value;
        logic fb;
        value = 0;
        for (int i = 0; i < n; i++) begin
            fb = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], fb};
            value = (value << 1) | int'(fb);
        end
        return value;
    endfunction

    // expected outputs for the current cycle from the reference state
    function automatic expect_t reference_outputs(bp_pkg::pc_t f_pc, logic f_taken,
                                                  bp_pkg::pc_t f_target);
        expect_t     e;
        logic [4:0]  gidx;
        gidx     = f_pc[5:1] ^ m_hist[4:0];
        e.target = m_btb[f_pc[5:1]];
        e.taken  = m_ctr[gidx][1];
        e.fix    = bp_pkg::FIX_NONE;
        if (m_exe.live) begin
            if (f_taken) begin
                if (m_dec.pc != f_target) begin
                    e.fix = m_exe.pred_taken ? bp_pkg::FIX_TARGET : bp_pkg::FIX_TAKEN;
                end
            end else if (m_exe.pred_taken) begin
                e.fix = bp_pkg::FIX_NOT_TAKEN;
            end
        end
        return e;
    endfunction

    // advance the reference across the coming rising edge
    task automatic update_model();
        expect_t       e;
        logic          miss;
        logic          valid;
        logic          accept;
        bp_pkg::hist_t retire;
        logic [4:0]    widx;
        if (rst_i) begin
            for (int i = 0; i < 32; i++) begin
                m_btb[i] = '0;
                m_ctr[i] = '0;
            end
            m_hist     = '0;
            m_inflight = '0;
            m_dec      = '0;
            m_exe      = '0;
            return;
        end
        e      = reference_outputs(pc, taken, target);
        miss   = (e.fix != bp_pkg::FIX_NONE);
        valid  = m_exe.live && !stall;
        accept = predict && !stall;
        retire = m_hist >> m_inflight; // history seen by the retiring branch
        widx   = m_exe.pc[5:1] ^ retire[4:0];
        if (valid && miss && taken) begin
            m_btb[m_exe.pc[5:1]] = target;
        end
        if (valid && !jump) begin
            if (taken && m_ctr[widx] != 2'd3) begin
                m_ctr[widx] = m_ctr[widx] + 2'd1;
            end else if (!taken && m_ctr[widx] != 2'd0) begin
                m_ctr[widx] = m_ctr[widx] - 2'd1;
            end
        end
        if (valid && miss) begin
            m_hist     = {retire[5:0], taken};
            m_inflight = '0;
        end else begin
            if (accept) begin
                m_hist = {m_hist[5:0], e.taken};
            end
            if (accept && !valid) begin
                m_inflight = m_inflight + 2'd1;
            end else if (!accept && valid) begin
                m_inflight = m_inflight - 2'd1;
            end
        end
        if (!stall) begin
            m_exe      = m_dec;
            m_exe.live = m_dec.live && !miss;
            m_dec      = {predict && !miss, pc, e.taken, compressed};
        end
    endtask

    // outputs are settled at the falling edge
    always @(negedge clk_i) begin
        expect_t e;
        if (!rst_i) begin
            e = reference_outputs(pc, taken, target);
            checks = checks + 3;
            if (pred_taken_o !== e.taken) begin
                errors++;
                $display("FAILED %s pred_taken expected %0h actual %0h",
                         test_name, e.taken, pred_taken_o);
            end
            if (pred_target_o !== e.target) begin
                errors++;
                $display("FAILED %s pred_target expected %0h actual %0h",
                         test_name, e.target, pred_target_o);
            end
            if (fix_o !== e.fix) begin
                errors++;
                $display("FAILED %s fix expected %0h actual %0h", test_name, e.fix, fix_o);
            end
            if (m_exe.live) begin
                checks = checks + 2;
                if (exe_pc_o !== m_exe.pc) begin
                    errors++;
                    $display("FAILED %s exe_pc expected %0h actual %0h",
                             test_name, m_exe.pc, exe_pc_o);
                end
                if (exe_compressed_o !== m_exe.compressed) begin
                    errors++;
                    $display("FAILED %s exe_compressed expected %0h actual %0h",
                             test_name, m_exe.compressed, exe_compressed_o);
                end
            end
        end
        update_model();
    end

    always @(posedge clk_i) begin
        cycle_count++;
        if (cycle_count > CYCLE_LIMIT) begin
            $display("timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("Test failed");
            $finish;
        end
    end

    task automatic drive(bp_pkg::pc_t d_pc, logic d_predict, logic d_comp, logic d_stall,
                         logic d_jump, logic d_taken, bp_pkg::pc_t d_target);
        @(posedge clk_i);
        #1;
        pc         = d_pc;
        predict    = d_predict;
        compressed = d_comp;
        stall      = d_stall;
        jump       = d_jump;
        taken      = d_taken;
        target     = d_target;
    endtask

    task automatic expect_value(string what, int expected, int actual);
        checks++;
        if (expected != actual) begin
            errors++;
            $display("FAILED %s %s expected %0h actual %0h", test_name, what, expected, actual);
        end
    endtask

    task automatic start_test(string name);
        test_name   = name;
        test_errors = errors;
    endtask

    task automatic finish_test();
        $display("test %s done, %0d errors", test_name, errors - test_errors);
    endtask

    // one branch through fetch, decode and execute, then a probe cycle
    task automatic issue_branch(bp_pkg::pc_t b_pc, logic follow, logic b_jump, logic b_taken,
                                bp_pkg::pc_t b_target, output logic p_taken,
                                output bp_pkg::pc_t p_target, output bp_pkg::fix_t fix_main,
                                output bp_pkg::fix_t fix_after);
        bp_pkg::pc_t next_pc;
        drive(b_pc, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, '0);
        @(negedge clk_i);
        p_taken  = pred_taken_o;
        p_target = pred_target_o;
        next_pc  = p_taken ? p_target : b_pc + bp_pkg::pc_t'(2);
        drive(next_pc, follow, 1'b0, 1'b0, 1'b0, 1'b0, '0);
        drive(b_pc + bp_pkg::pc_t'(9), follow, 1'b0, 1'b0, b_jump, b_taken, b_target);
        @(negedge clk_i);
        fix_main = fix_o;
        // a live entry here would miss, since decode never matches this target
        drive(b_pc + bp_pkg::pc_t'(16), 1'b0, 1'b0, 1'b0, 1'b0, 1'b1,
              b_pc + bp_pkg::pc_t'(12));
        @(negedge clk_i);
        fix_after = fix_o;
        drive(b_pc + bp_pkg::pc_t'(24), 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, '0);
    endtask

    task automatic train_taken(bp_pkg::pc_t b_pc, bp_pkg::pc_t b_target,
                               output bp_pkg::fix_t first_fix);
        logic         p_taken;
        bp_pkg::pc_t  p_target;
        bp_pkg::fix_t fix_main;
        bp_pkg::fix_t fix_after;
        bit           trained;
        trained = 0;
        for (int i = 0; i < TRAIN_MAX && !trained; i++) begin
            issue_branch(b_pc, 1'b0, 1'b0, 1'b1, b_target, p_taken, p_target, fix_main,
                         fix_after);
            if (i == 0) begin
                first_fix = fix_main;
            end
            trained = p_taken && p_target == b_target && fix_main == bp_pkg::FIX_NONE;
        end
        if (!trained) begin
            errors++;
            $display("%s: branch at %0h never became predicted taken", test_name, b_pc);
        end
    endtask

    initial begin
        logic         p_taken;
        bp_pkg::pc_t  p_target;
        bp_pkg::fix_t fix_main;
        bp_pkg::fix_t fix_after;
        bp_pkg::fix_t first_fix;
        bp_pkg::pc_t  fetch_pc;
        bp_pkg::pc_t  rand_targets [4];
        logic         r_stall;
        logic         r_predict;
        logic         r_comp;
        logic         r_jump;
        logic         r_taken;
        bp_pkg::pc_t  r_target;
        logic         exp_taken;
        int           sel;

        clk_i      = 1'b0;
        rst_i      = 1'b1;
        stall      = 1'b0;
        pc         = '0;
        predict    = 1'b0;
        compressed = 1'b0;
        jump       = 1'b0;
        taken      = 1'b0;
        target     = '0;
        repeat (2) @(posedge clk_i);
        #1;
        rst_i = 1'b0;

        start_test("reset");
        drive(18'h00055, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, '0);
        for (int i = 0; i < 2; i++) begin
            @(negedge clk_i);
            expect_value("pred_taken", 0, int'(pred_taken_o));
            expect_value("pred_target", 0, int'(pred_target_o));
            expect_value("fix", int'(bp_pkg::FIX_NONE), int'(fix_o));
            if (i == 0) begin
                drive(18'h001ab, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, '0);
            end
        end
        finish_test();

        start_test("always_taken");
        train_taken(18'h00040, 18'h00200, first_fix);
        expect_value("first fix", int'(bp_pkg::FIX_TAKEN), int'(first_fix));
        finish_test();

        start_test("fall_through");
        issue_branch(18'h00040, 1'b1, 1'b0, 1'b0, '0, p_taken, p_target, fix_main, fix_after);
        expect_value("fix", int'(bp_pkg::FIX_NOT_TAKEN), int'(fix_main));
        expect_value("fix after flush", int'(bp_pkg::FIX_NONE), int'(fix_after));
        finish_test();

        start_test("target_change");
        train_taken(18'h00040, 18'h00200, first_fix);
        issue_branch(18'h00040, 1'b0, 1'b0, 1'b1, 18'h00300, p_taken, p_target, fix_main,
                     fix_after);
        expect_value("fix", int'(bp_pkg::FIX_TARGET), int'(fix_main));
        issue_branch(18'h00040, 1'b0, 1'b0, 1'b1, 18'h00300, p_taken, p_target, fix_main,
                     fix_after);
        expect_value("new target", 18'h00300, int'(p_target));
        expect_value("fix", int'(bp_pkg::FIX_NONE), int'(fix_main));
        finish_test();

        start_test("jump");
        for (int i = 0; i < 8; i++) begin
            issue_branch(18'h00105, 1'b0, 1'b1, 1'b1, 18'h003a0, p_taken, p_target,
                         fix_main, fix_after);
            // counters never move for jumps, so it stays predicted not taken
            expect_value("pred_taken", 0, int'(p_taken));
            expect_value("fix", int'(bp_pkg::FIX_TAKEN), int'(fix_main));
            if (i > 0) begin
                expect_value("jump target", 18'h003a0, int'(p_target));
            end
        end
        drive(18'h00080, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, '0);
        exp_taken = m_ctr[5'h00 ^ m_hist[4:0]][1]; // repaired history index
        @(negedge clk_i);
        expect_value("repaired history prediction", int'(exp_taken), int'(pred_taken_o));
        repeat (3) drive(18'h00090, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, '0);
        finish_test();

        start_test("random");
        rand_targets[0] = 18'h00040;
        rand_targets[1] = 18'h000a4;
        rand_targets[2] = 18'h00113;
        rand_targets[3] = 18'h002c6;
        fetch_pc = 18'h00040;
        for (int i = 0; i < RAND_CYCLES; i++) begin
            r_stall   = (take_bits(3) == 0);
            r_predict = (take_bits(1) != 0);
            r_comp    = (take_bits(1) != 0);
            r_jump    = (take_bits(3) == 0);
            r_taken   = r_jump || (take_bits(2) != 0);
            sel       = take_bits(3);
            r_target  = rand_targets[sel % 4];
            drive(fetch_pc, r_predict, r_comp, r_stall, r_jump, r_taken, r_target);
            if (sel > 3) begin
                // decode pc after this edge, so the target sometimes hits
                r_target = m_dec.pc;
                target   = r_target;
            end
            @(negedge clk_i);
            if (r_stall) begin
                fetch_pc = fetch_pc; // fetch repeats its pc
            end else if (fix_o != bp_pkg::FIX_NONE) begin
                fetch_pc = r_taken ? r_target
                                   : exe_pc_o + bp_pkg::pc_t'(exe_compressed_o ? 1 : 2);
            end else if (r_predict && pred_taken_o) begin
                fetch_pc = pred_target_o;
            end else begin
                fetch_pc = fetch_pc + bp_pkg::pc_t'(r_comp ? 1 : 2);
            end
        end
        finish_test();

        @(posedge clk_i);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0 && checks > 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

// ==== sim.f ====
rtl/bp_pkg.sv
rtl/branch_target_buffer.sv
rtl/pattern_history_table.sv
rtl/global_history.sv
rtl/resolve_tracker.sv
rtl/branch_predictor.sv
bench/branch_predictor_assertions.sv
bench/branch_predictor_tb.sv

// ==== Makefile ====
.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f sim.f --top-module branch_predictor_tb -o sim_bp
	out=$$(./obj_dir/sim_bp); \
	echo "$$out"; \
	echo "$$out" | grep -q "Test passed"

clean:
	rm -rf obj_dir
